// ==== hw/lsu_pkg.sv ====
package lsu_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 64;
    localparam int STRB_W     = DATA_W / 8;
    localparam int CFG_ADDR_W = 2;

    // core-side request type
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    // bytes = 1 << size, same coding as AXI size up to 8 bytes
    typedef enum logic [1:0] {
        SZ_B = 2'd0,
        SZ_H = 2'd1,
        SZ_W = 2'd2,
        SZ_D = 2'd3
    } mem_size_e;

    // config register map
    typedef enum logic [CFG_ADDR_W-1:0] {
        REG_WIN_BASE  = 2'd0,
        REG_WIN_LIMIT = 2'd1,
        REG_ERR_COUNT = 2'd2,   // any write clears
        REG_LAST_ERR  = 2'd3    // read only
    } cfg_reg_e;

endpackage

// ==== hw/axi_pkg.sv ====
package axi_pkg;

    localparam int AXI_ID_W = 4;

    // fixed attributes driven by the bridge
    localparam logic [AXI_ID_W-1:0] AXI_ID_LSU       = 4'd1;
    localparam logic [2:0]          AXI_PROT_DATA    = 3'b000;  // unpriv, secure, data
    localparam logic [1:0]          AXI_BURST_INCR   = 2'b01;
    localparam logic [3:0]          AXI_CACHE_NORMAL = 4'b0010; // normal, non-cacheable

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    // slave depth in 64-bit words, 512 bytes
    localparam int SRAM_WORDS = 64;
    localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);

endpackage

// ==== hw/lsu_cfg_regs.sv ====
`timescale 1ns/1ns

module lsu_cfg_regs (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             cfg_we_i,
    input  logic [lsu_pkg::CFG_ADDR_W-1:0]   cfg_addr_i,
    input  logic [lsu_pkg::ADDR_W-1:0]       cfg_wdata_i,
    output logic [lsu_pkg::ADDR_W-1:0]       cfg_rdata_o,
    output logic [lsu_pkg::ADDR_W-1:0]       win_base_o,
    output logic [lsu_pkg::ADDR_W-1:0]       win_limit_o,
    input  logic                             err_pulse_i,
    input  logic [lsu_pkg::ADDR_W-1:0]       err_addr_i
);
    import lsu_pkg::*;

    logic [ADDR_W-1:0] win_base_q;
    logic [ADDR_W-1:0] win_limit_q;
    logic [ADDR_W-1:0] err_cnt_q;
    logic [ADDR_W-1:0] last_err_q;
    logic              clr_cnt;

    assign clr_cnt = cfg_we_i && (cfg_addr_i == REG_ERR_COUNT);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            win_base_q  <= '0;
            win_limit_q <= '1;          // whole space open
            err_cnt_q   <= '0;
            last_err_q  <= '0;
        end else begin
            if (cfg_we_i && cfg_addr_i == REG_WIN_BASE)
                win_base_q <= cfg_wdata_i;
            if (cfg_we_i && cfg_addr_i == REG_WIN_LIMIT)
                win_limit_q <= cfg_wdata_i;
            if (clr_cnt)
                err_cnt_q <= '0;        // clear beats a same-cycle error
            else if (err_pulse_i && err_cnt_q != '1)
                err_cnt_q <= err_cnt_q + 1'b1;
            if (err_pulse_i)
                last_err_q <= err_addr_i;
        end
    end

    always_comb begin
        case (cfg_addr_i)
            REG_WIN_BASE:  cfg_rdata_o = win_base_q;
            REG_WIN_LIMIT: cfg_rdata_o = win_limit_q;
            REG_ERR_COUNT: cfg_rdata_o = err_cnt_q;
            default:       cfg_rdata_o = last_err_q;
        endcase
    end

    assign win_base_o  = win_base_q;
    assign win_limit_o = win_limit_q;

endmodule

// ==== hw/lsu_axi_master.sv ====
`timescale 1ns/1ns

module lsu_axi_master (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           req_valid_i,
    input  lsu_pkg::mem_op_e               req_op_i,
    input  lsu_pkg::mem_size_e             req_size_i,
    input  logic [lsu_pkg::ADDR_W-1:0]     req_addr_i,
    input  logic [lsu_pkg::DATA_W-1:0]     req_wdata_i,
    output logic                           busy_o,
    output logic                           done_o,
    output logic [lsu_pkg::DATA_W-1:0]     rdata_o,
    output logic                           err_o,
    input  logic [lsu_pkg::ADDR_W-1:0]     win_base_i,
    input  logic [lsu_pkg::ADDR_W-1:0]     win_limit_i,
    output logic                           err_pulse_o,
    output logic [lsu_pkg::ADDR_W-1:0]     err_addr_o,
    output logic                           aw_valid_o,
    input  logic                           aw_ready_i,
    output logic [lsu_pkg::ADDR_W-1:0]     aw_addr_o,
    output logic [2:0]                     aw_size_o,
    output logic [axi_pkg::AXI_ID_W-1:0]   aw_id_o,
    output logic [2:0]                     aw_prot_o,
    output logic [3:0]                     aw_cache_o,
    output logic [1:0]                     aw_burst_o,
    output logic [7:0]                     aw_len_o,
    output logic                           w_valid_o,
    input  logic                           w_ready_i,
    output logic [lsu_pkg::DATA_W-1:0]     w_data_o,
    output logic [lsu_pkg::STRB_W-1:0]     w_strb_o,
    output logic                           w_last_o,
    input  logic                           b_valid_i,
    output logic                           b_ready_o,
    input  axi_pkg::axi_resp_e             b_resp_i,
    output logic                           ar_valid_o,
    input  logic                           ar_ready_i,
    output logic [lsu_pkg::ADDR_W-1:0]     ar_addr_o,
    output logic [2:0]                     ar_size_o,
    output logic [axi_pkg::AXI_ID_W-1:0]   ar_id_o,
    output logic [2:0]                     ar_prot_o,
    output logic [3:0]                     ar_cache_o,
    output logic [1:0]                     ar_burst_o,
    output logic [7:0]                     ar_len_o,
    input  logic                           r_valid_i,
    output logic                           r_ready_o,
    input  logic [lsu_pkg::DATA_W-1:0]     r_data_i,
    input  axi_pkg::axi_resp_e             r_resp_i
);
    import lsu_pkg::*;
    import axi_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE, ST_AW, ST_W, ST_B, ST_AR, ST_R, ST_DONE, ST_BLOCK
    } state_e;

    state_e            state_q, state_d;
    mem_size_e         size_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic [DATA_W-1:0] rdata_q;
    logic              err_q;
    logic              accept;
    logic              in_win;
    logic [2:0]        off;         // byte lane of the access
    logic [STRB_W-1:0] size_strb;   // right-aligned byte mask
    logic [DATA_W-1:0] size_bits;

    assign accept = (state_q == ST_IDLE) && req_valid_i;
    assign in_win = (req_addr_i >= win_base_i) && (req_addr_i <= win_limit_i);
    assign off    = addr_q[2:0];

    always_comb begin
        size_strb = STRB_W'((32'd1 << (32'd1 << size_q)) - 32'd1);
        for (int i = 0; i < STRB_W; i++) begin
            size_bits[i*8 +: 8] = {8{size_strb[i]}};
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_valid_i) begin
                    if (!in_win)
                        state_d = ST_BLOCK;     // refused locally
                    else if (req_op_i == OP_WRITE)
                        state_d = ST_AW;
                    else
                        state_d = ST_AR;
                end
            end
            ST_AW:   if (aw_ready_i) state_d = ST_W;
            ST_W:    if (w_ready_i) state_d = ST_B;
            ST_B:    if (b_valid_i) state_d = ST_DONE;
            ST_AR:   if (ar_ready_i) state_d = ST_R;
            ST_R:    if (r_valid_i) state_d = ST_DONE;
            default: state_d = ST_IDLE;      // DONE, BLOCK
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= ST_IDLE;
            err_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept)
                err_q <= 1'b0;
            else if (state_q == ST_B && b_valid_i)
                err_q <= (b_resp_i != RESP_OKAY);
            else if (state_q == ST_R && r_valid_i)
                err_q <= (r_resp_i != RESP_OKAY);
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            size_q  <= req_size_i;
            addr_q  <= req_addr_i;
            wdata_q <= req_wdata_i;
            rdata_q <= '0;
        end else if (state_q == ST_R && r_valid_i) begin
            // selected bytes down to bit 0, upper bits zero
            rdata_q <= (r_resp_i == RESP_OKAY) ? ((r_data_i >> {off, 3'b000}) & size_bits) : '0;
        end
    end

    assign busy_o      = (state_q != ST_IDLE);
    assign done_o      = (state_q == ST_DONE) || (state_q == ST_BLOCK);
    assign err_o       = ((state_q == ST_DONE) && err_q) || (state_q == ST_BLOCK);
    assign rdata_o     = rdata_q;
    assign err_pulse_o = err_o;
    assign err_addr_o  = addr_q;

    assign aw_valid_o = (state_q == ST_AW);
    assign aw_addr_o  = {addr_q[ADDR_W-1:3], 3'b000};
    assign aw_size_o  = {1'b0, size_q};
    assign aw_id_o    = AXI_ID_LSU;
    assign aw_prot_o  = AXI_PROT_DATA;
    assign aw_cache_o = AXI_CACHE_NORMAL;
    assign aw_burst_o = AXI_BURST_INCR;
    assign aw_len_o   = 8'd0;           // single beat

    assign w_valid_o  = (state_q == ST_W);
    assign w_data_o   = wdata_q << {off, 3'b000};
    assign w_strb_o   = size_strb << off;
    assign w_last_o   = 1'b1;
    assign b_ready_o  = (state_q == ST_B);

    assign ar_valid_o = (state_q == ST_AR);
    assign ar_addr_o  = {addr_q[ADDR_W-1:3], 3'b000};
    assign ar_size_o  = {1'b0, size_q};
    assign ar_id_o    = AXI_ID_LSU;
    assign ar_prot_o  = AXI_PROT_DATA;
    assign ar_cache_o = AXI_CACHE_NORMAL;
    assign ar_burst_o = AXI_BURST_INCR;
    assign ar_len_o   = 8'd0;
    assign r_ready_o  = (state_q == ST_R);

endmodule

// ==== hw/axi_sram_slave.sv ====
`timescale 1ns/1ns

module axi_sram_slave (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           aw_valid_i,
    output logic                           aw_ready_o,
    input  logic [lsu_pkg::ADDR_W-1:0]     aw_addr_i,
    input  logic [axi_pkg::AXI_ID_W-1:0]   aw_id_i,
    input  logic                           w_valid_i,
    output logic                           w_ready_o,
    input  logic [lsu_pkg::DATA_W-1:0]     w_data_i,
    input  logic [lsu_pkg::STRB_W-1:0]     w_strb_i,
    output logic                           b_valid_o,
    input  logic                           b_ready_i,
    output axi_pkg::axi_resp_e             b_resp_o,
    output logic [axi_pkg::AXI_ID_W-1:0]   b_id_o,
    input  logic                           ar_valid_i,
    output logic                           ar_ready_o,
    input  logic [lsu_pkg::ADDR_W-1:0]     ar_addr_i,
    input  logic [axi_pkg::AXI_ID_W-1:0]   ar_id_i,
    output logic                           r_valid_o,
    input  logic                           r_ready_i,
    output logic [lsu_pkg::DATA_W-1:0]     r_data_o,
    output axi_pkg::axi_resp_e             r_resp_o,
    output logic [axi_pkg::AXI_ID_W-1:0]   r_id_o
);
    import lsu_pkg::*;
    import axi_pkg::*;

    typedef enum logic [1:0] {
        WS_IDLE, WS_DATA, WS_RESP
    } wstate_e;

    typedef enum logic {
        RS_IDLE, RS_DATA
    } rstate_e;

    wstate_e           wstate_q;
    rstate_e           rstate_q;
    logic [DATA_W-1:0] mem [SRAM_WORDS];
    logic [ADDR_W-4:0] aw_word_q;       // latched word index
    logic [ADDR_W-4:0] ar_word;
    logic              aw_hit;
    logic              ar_hit;

    assign aw_hit  = (aw_word_q < SRAM_WORDS);
    assign ar_word = ar_addr_i[ADDR_W-1:3];
    assign ar_hit  = (ar_word < SRAM_WORDS);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wstate_q <= WS_IDLE;
        end else begin
            case (wstate_q)
                WS_IDLE: if (aw_valid_i) wstate_q <= WS_DATA;
                WS_DATA: if (w_valid_i) wstate_q <= WS_RESP;
                WS_RESP: if (b_ready_i) wstate_q <= WS_IDLE;
                default: wstate_q <= WS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (aw_valid_i && aw_ready_o) begin
            aw_word_q <= aw_addr_i[ADDR_W-1:3];
            b_id_o    <= aw_id_i;
        end
        if (w_valid_i && w_ready_o) begin
            b_resp_o <= aw_hit ? RESP_OKAY : RESP_SLVERR;
            if (aw_hit) begin
                // byte merge under strobes
                for (int i = 0; i < STRB_W; i++) begin
                    if (w_strb_i[i])
                        mem[aw_word_q[SRAM_IDX_W-1:0]][i*8 +: 8] <= w_data_i[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            rstate_q <= RS_IDLE;
        end else begin
            case (rstate_q)
                RS_IDLE: if (ar_valid_i) rstate_q <= RS_DATA;
                default: if (r_ready_i) rstate_q <= RS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (ar_valid_i && ar_ready_o) begin
            r_data_o <= ar_hit ? mem[ar_word[SRAM_IDX_W-1:0]] : '0;
            r_resp_o <= ar_hit ? RESP_OKAY : RESP_SLVERR;
            r_id_o   <= ar_id_i;
        end
    end

    assign aw_ready_o = (wstate_q == WS_IDLE);
    assign w_ready_o  = (wstate_q == WS_DATA);
    assign b_valid_o  = (wstate_q == WS_RESP);
    assign ar_ready_o = (rstate_q == RS_IDLE);
    assign r_valid_o  = (rstate_q == RS_DATA);  // one cycle after AR

endmodule

// ==== hw/lsu_subsystem.sv ====
`timescale 1ns/1ns

module lsu_subsystem (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             req_valid_i,
    input  lsu_pkg::mem_op_e                 req_op_i,
    input  lsu_pkg::mem_size_e               req_size_i,
    input  logic [lsu_pkg::ADDR_W-1:0]       req_addr_i,
    input  logic [lsu_pkg::DATA_W-1:0]       req_wdata_i,
    output logic                             busy_o,
    output logic                             done_o,
    output logic [lsu_pkg::DATA_W-1:0]       rdata_o,
    output logic                             err_o,
    input  logic                             cfg_we_i,
    input  logic [lsu_pkg::CFG_ADDR_W-1:0]   cfg_addr_i,
    input  logic [lsu_pkg::ADDR_W-1:0]       cfg_wdata_i,
    output logic [lsu_pkg::ADDR_W-1:0]       cfg_rdata_o
);
    import lsu_pkg::*;
    import axi_pkg::*;

    logic [ADDR_W-1:0]   win_base, win_limit, err_addr;
    logic                err_pulse;
    logic                aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic                ar_valid, ar_ready, r_valid, r_ready;
    logic [ADDR_W-1:0]   aw_addr, ar_addr;
    logic [AXI_ID_W-1:0] aw_id, ar_id;
    logic [DATA_W-1:0]   w_data, r_data;
    logic [STRB_W-1:0]   w_strb;
    axi_resp_e           b_resp, r_resp;

    lsu_cfg_regs u_cfg (
        .clock, .reset,
        .cfg_we_i, .cfg_addr_i, .cfg_wdata_i, .cfg_rdata_o,
        .win_base_o (win_base), .win_limit_o (win_limit),
        .err_pulse_i (err_pulse), .err_addr_i (err_addr)
    );

    // attribute outputs stay open, the slave ignores them
    lsu_axi_master u_master (
        .clock, .reset,
        .req_valid_i, .req_op_i, .req_size_i, .req_addr_i, .req_wdata_i,
        .busy_o, .done_o, .rdata_o, .err_o,
        .win_base_i (win_base), .win_limit_i (win_limit),
        .err_pulse_o (err_pulse), .err_addr_o (err_addr),
        .aw_valid_o (aw_valid), .aw_ready_i (aw_ready), .aw_addr_o (aw_addr),
        .aw_size_o (), .aw_id_o (aw_id), .aw_prot_o (), .aw_cache_o (),
        .aw_burst_o (), .aw_len_o (),
        .w_valid_o (w_valid), .w_ready_i (w_ready), .w_data_o (w_data),
        .w_strb_o (w_strb), .w_last_o (),
        .b_valid_i (b_valid), .b_ready_o (b_ready), .b_resp_i (b_resp),
        .ar_valid_o (ar_valid), .ar_ready_i (ar_ready), .ar_addr_o (ar_addr),
        .ar_size_o (), .ar_id_o (ar_id), .ar_prot_o (), .ar_cache_o (),
        .ar_burst_o (), .ar_len_o (),
        .r_valid_i (r_valid), .r_ready_o (r_ready), .r_data_i (r_data),
        .r_resp_i (r_resp)
    );

    axi_sram_slave u_sram (
        .clock, .reset,
        .aw_valid_i (aw_valid), .aw_ready_o (aw_ready), .aw_addr_i (aw_addr),
        .aw_id_i (aw_id),
        .w_valid_i (w_valid), .w_ready_o (w_ready), .w_data_i (w_data), .w_strb_i (w_strb),
        .b_valid_o (b_valid), .b_ready_i (b_ready), .b_resp_o (b_resp), .b_id_o (),
        .ar_valid_i (ar_valid), .ar_ready_o (ar_ready), .ar_addr_i (ar_addr),
        .ar_id_i (ar_id),
        .r_valid_o (r_valid), .r_ready_i (r_ready), .r_data_o (r_data),
        .r_resp_o (r_resp), .r_id_o ()
    );

endmodule

// ==== test/lsu_assertions.sv ====
`timescale 1ns/1ns

module lsu_assertions (
    input logic                       clock,
    input logic                       reset,
    input logic                       req_valid_i,
    input lsu_pkg::mem_op_e           req_op_i,
    input logic [lsu_pkg::ADDR_W-1:0] req_addr_i,
    input logic [lsu_pkg::ADDR_W-1:0] win_base_i,
    input logic [lsu_pkg::ADDR_W-1:0] win_limit_i,
    input logic                       busy_i,
    input logic                       done_i,
    input logic                       err_i,
    input logic                       aw_valid_i,
    input logic                       aw_ready_i,
    input logic                       w_valid_i,
    input logic                       w_ready_i,
    input logic                       ar_valid_i,
    input logic                       ar_ready_i,
    input logic                       b_valid_i,
    input logic                       b_ready_i,
    input logic                       r_valid_i,
    input logic                       r_ready_i
);
    import lsu_pkg::*;

    int   fail_count = 0;  // read by the testbench summary
    logic strobe;
    logic in_win;

    assign strobe = req_valid_i && !busy_i;
    assign in_win = (req_addr_i >= win_base_i) && (req_addr_i <= win_limit_i);

    write_latency: assert property (@(posedge clock) disable iff (!reset)
        strobe && in_win && req_op_i == OP_WRITE |=> !done_i [*3] ##1 done_i)
        else begin $error("in-window write did not finish in 4 cycles"); fail_count++; end

    read_latency: assert property (@(posedge clock) disable iff (!reset)
        strobe && in_win && req_op_i == OP_READ |=> !done_i [*2] ##1 done_i)
        else begin $error("in-window read did not finish in 3 cycles"); fail_count++; end

    // refused locally, no bus traffic
    block_latency: assert property (@(posedge clock) disable iff (!reset)
        strobe && !in_win |=> done_i && err_i && !aw_valid_i && !ar_valid_i)
        else begin $error("out-of-window access not refused in 1 cycle"); fail_count++; end

    done_pulse: assert property (@(posedge clock) disable iff (!reset)
        done_i |-> busy_i ##1 (!done_i && !busy_i))
        else begin $error("done_o longer than one cycle or busy_o stuck"); fail_count++; end

    no_strobe_busy: assert property (@(posedge clock) disable iff (!reset)
        busy_i |-> !req_valid_i)
        else begin $error("request strobe while busy"); fail_count++; end

    aw_hold: assert property (@(posedge clock) disable iff (!reset)
        aw_valid_i && !aw_ready_i |=> aw_valid_i)
        else begin $error("aw_valid dropped before aw_ready"); fail_count++; end

    w_hold: assert property (@(posedge clock) disable iff (!reset)
        w_valid_i && !w_ready_i |=> w_valid_i)
        else begin $error("w_valid dropped before w_ready"); fail_count++; end

    ar_hold: assert property (@(posedge clock) disable iff (!reset)
        ar_valid_i && !ar_ready_i |=> ar_valid_i)
        else begin $error("ar_valid dropped before ar_ready"); fail_count++; end

    reset_quiet: assert property (@(posedge clock) !reset |=> !done_i && !busy_i && !err_i
        && !aw_valid_i && !w_valid_i && !ar_valid_i && !b_valid_i && !r_valid_i
        && !b_ready_i && !r_ready_i)
        else begin $error("outputs active after reset"); fail_count++; end

endmodule

bind lsu_subsystem lsu_assertions u_assert (
    .clock, .reset, .req_valid_i, .req_op_i, .req_addr_i,
    .win_base_i (win_base), .win_limit_i (win_limit),
    .busy_i (busy_o), .done_i (done_o), .err_i (err_o),
    .aw_valid_i (aw_valid), .aw_ready_i (aw_ready),
    .w_valid_i (w_valid), .w_ready_i (w_ready),
    .ar_valid_i (ar_valid), .ar_ready_i (ar_ready),
    .b_valid_i (b_valid), .b_ready_i (b_ready),
    .r_valid_i (r_valid), .r_ready_i (r_ready)
);

// ==== test/tb_lsu_subsystem.sv ====
`timescale 1ns/1ns

module tb_lsu_subsystem;
    import lsu_pkg::*;
    import axi_pkg::*;

    localparam int SRAM_BYTES = SRAM_WORDS * STRB_W;
    localparam int N_REQ      = 70;             // core-side requests over all tests
    localparam int TIMEOUT    = N_REQ * 6 + 50;

    logic              clock, reset;
    logic              req_valid_i;
    mem_op_e           req_op_i;
    mem_size_e         req_size_i;
    logic [ADDR_W-1:0] req_addr_i;
    logic [DATA_W-1:0] req_wdata_i;
    logic              busy_o, done_o, err_o;
    logic [DATA_W-1:0] rdata_o;
    logic              cfg_we_i;
    logic [1:0]        cfg_addr_i;
    logic [31:0]       cfg_wdata_i, cfg_rdata_o;

    logic [7:0]  ref_mem [SRAM_BYTES];          // byte model of the sram
    logic [31:0] win_base_m, win_limit_m, last_err_m, lcg_state;
    int          err_count_m, checks, errors, tests_passed, tests_failed;
    int          cycle_cnt, errors_at, asserts_at;

    lsu_subsystem dut (
        .clock, .reset, .req_valid_i, .req_op_i, .req_size_i, .req_addr_i, .req_wdata_i,
        .busy_o, .done_o, .rdata_o, .err_o, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i, .cfg_rdata_o
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [63:0] rand64();
        return {next_rand(), next_rand()};
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic run_request(input mem_op_e op, input mem_size_e size,
                               input logic [31:0] addr, input logic [63:0] wdata);
        int          nbytes;
        logic        exp_err;
        logic [63:0] exp_rdata;
        nbytes    = 1 << size;
        exp_err   = (addr < win_base_m) || (addr > win_limit_m) || (addr >= SRAM_BYTES);
        exp_rdata = '0;
        if (exp_err) begin
            err_count_m++;
            last_err_m = addr;
        end else begin
            for (int i = 0; i < nbytes; i++) begin
                if (op == OP_WRITE)
                    ref_mem[addr + i] = wdata[i*8 +: 8];
                else
                    exp_rdata[i*8 +: 8] = ref_mem[addr + i];
            end
        end
        @(posedge clock);
        req_valid_i <= 1'b1;
        req_op_i    <= op;
        req_size_i  <= size;
        req_addr_i  <= addr;
        req_wdata_i <= wdata;
        @(posedge clock);
        req_valid_i <= 1'b0;
        do @(negedge clock); while (!done_o);
        check_value($sformatf("%s at %h err_o", op.name(), addr), err_o, exp_err);
        if (op == OP_READ || exp_err)
            check_value($sformatf("%s at %h rdata_o", op.name(), addr), rdata_o, exp_rdata);
    endtask

    task automatic write_cfg(input cfg_reg_e sel, input logic [31:0] data);
        @(posedge clock);
        cfg_we_i    <= 1'b1;
        cfg_addr_i  <= sel;
        cfg_wdata_i <= data;
        @(posedge clock);
        cfg_we_i <= 1'b0;
        case (sel)
            REG_WIN_BASE:  win_base_m = data;
            REG_WIN_LIMIT: win_limit_m = data;
            REG_ERR_COUNT: err_count_m = 0;     // any write clears
            default: ;
        endcase
    endtask

    task automatic check_cfg(input cfg_reg_e sel, input logic [31:0] exp);
        @(posedge clock);
        cfg_addr_i <= sel;
        @(negedge clock);
        check_value(sel.name(), cfg_rdata_o, exp);
    endtask

    task automatic begin_test();
        errors_at  = errors;
        asserts_at = dut.u_assert.fail_count;
    endtask

    task automatic end_test(input int num, input string name);
        int bad;
        bad = (errors - errors_at) + (dut.u_assert.fail_count - asserts_at);
        if (bad == 0) begin
            tests_passed++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d failures", num, name, bad);
        end
    endtask

    // run limit
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT) begin
            @(posedge clock);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, done_o never arrived", cycle_cnt);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        logic [31:0] base;
        mem_size_e   sz;
        int          step;
        reset = 1'b0;
        req_valid_i = 1'b0;
        req_op_i = OP_READ;
        req_size_i = SZ_D;
        req_addr_i = '0;
        req_wdata_i = '0;
        cfg_we_i = 1'b0;
        cfg_addr_i = '0;
        cfg_wdata_i = '0;
        lcg_state = 32'd20;
        win_base_m = '0;
        win_limit_m = '1;
        last_err_m = '0;
        err_count_m = 0;
        checks = 0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (2) @(posedge clock);
        reset <= 1'b1;

        begin_test();
        for (int n = 0; n < 8; n++) begin
            base = ((next_rand() >> 16) % SRAM_WORDS) * 8;
            run_request(OP_WRITE, SZ_D, base, rand64());
            run_request(OP_READ, SZ_D, base, '0);
        end
        end_test(1, "doubleword write/read");

        begin_test();
        for (int s = 0; s < 3; s++) begin
            sz   = mem_size_e'(s);
            step = 1 << s;
            base = ((next_rand() >> 16) % SRAM_WORDS) * 8;
            run_request(OP_WRITE, SZ_D, base, rand64());    // background
            for (int off = 0; off < 8; off += step)
                run_request(OP_WRITE, sz, base + off, rand64());
            run_request(OP_READ, SZ_D, base, '0);
            for (int off = 0; off < 8; off += step)
                run_request(OP_READ, sz, base + off, '0);
        end
        end_test(2, "narrow lanes");

        begin_test();
        run_request(OP_WRITE, SZ_D, 32'd0, rand64());
        run_request(OP_WRITE, SZ_D, 32'd40, rand64());
        run_request(OP_WRITE, SZ_D, 32'd512, rand64());     // low index bits alias word 0
        run_request(OP_WRITE, SZ_D, 32'd552, rand64());
        run_request(OP_READ, SZ_D, 32'd512, '0);
        run_request(OP_READ, SZ_D, 32'h1000, '0);
        run_request(OP_READ, SZ_D, 32'd0, '0);
        run_request(OP_READ, SZ_D, 32'd40, '0);
        end_test(3, "out of range");

        begin_test();
        run_request(OP_WRITE, SZ_D, 32'd32, rand64());
        run_request(OP_WRITE, SZ_D, 32'd256, rand64());
        write_cfg(REG_WIN_BASE, 32'd64);
        write_cfg(REG_WIN_LIMIT, 32'd255);
        check_cfg(REG_WIN_BASE, 32'd64);
        check_cfg(REG_WIN_LIMIT, 32'd255);
        run_request(OP_WRITE, SZ_D, 32'd32, rand64());
        run_request(OP_WRITE, SZ_W, 32'd256, rand64());
        run_request(OP_READ, SZ_H, 32'd300, '0);
        run_request(OP_WRITE, SZ_D, 32'd128, rand64());
        run_request(OP_READ, SZ_D, 32'd128, '0);
        run_request(OP_WRITE, SZ_B, 32'd255, rand64());     // top edge of the window
        run_request(OP_READ, SZ_B, 32'd255, '0);
        write_cfg(REG_WIN_BASE, 32'd0);
        write_cfg(REG_WIN_LIMIT, 32'hffff_ffff);
        run_request(OP_READ, SZ_D, 32'd32, '0);
        run_request(OP_READ, SZ_D, 32'd256, '0);
        end_test(4, "access window");

        begin_test();
        check_cfg(REG_ERR_COUNT, err_count_m);
        check_cfg(REG_LAST_ERR, last_err_m);
        write_cfg(REG_ERR_COUNT, 32'h5a5a_5a5a);
        check_cfg(REG_ERR_COUNT, 32'd0);
        run_request(OP_READ, SZ_W, 32'd600, '0);
        check_cfg(REG_ERR_COUNT, err_count_m);
        check_cfg(REG_LAST_ERR, last_err_m);
        end_test(5, "error counter");

        $display("summary: %0d tests passed, %0d failed, %0d checks, %0d mismatches",
                 tests_passed, tests_failed, checks, errors);
        if (tests_failed == 0 && errors == 0 && dut.u_assert.fail_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== tb.f ====
hw/lsu_pkg.sv
hw/axi_pkg.sv
hw/lsu_cfg_regs.sv
hw/lsu_axi_master.sv
hw/axi_sram_slave.sv
hw/lsu_subsystem.sv
test/lsu_assertions.sv
test/tb_lsu_subsystem.sv

// ==== Bender.yml ====
package:
  name: lsu_subsystem

sources:
  - files:
      - hw/lsu_pkg.sv
      - hw/axi_pkg.sv
      - hw/lsu_cfg_regs.sv
      - hw/lsu_axi_master.sv
      - hw/axi_sram_slave.sv
      - hw/lsu_subsystem.sv
  - target: test
    files:
      - test/lsu_assertions.sv
      - test/tb_lsu_subsystem.sv
